//--- Makefile
TOP := cacheline_adapter_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove the build folder and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if grep -q "=== FAIL ===" sim.log; then exit 1; fi; \
	exit $$rc

clean:
	rm -rf obj_dir sim.log

//--- adapter_chk.sv
`timescale 1ns/1ps

module adapter_chk (
    input logic clk,
    input logic reset_i,
    input logic bmem_read_i,
    input logic bmem_write_i,
    input logic dfp_resp_i,
    input logic q_push_i,
    input logic q_pop_i,
    input logic q_full_i,
    input logic q_empty_i
);

    // Only one burst direction at a time
    rw_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(bmem_read_i && bmem_write_i))
        else $error("burst read and write strobes high together");

    // Response is a single cycle pulse
    resp_single: assert property (@(posedge clk) disable iff (reset_i)
        dfp_resp_i |=> !dfp_resp_i)
        else $error("cache response high for two cycles in a row");

    // Queue is drained fast enough that it never overflows
    no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        !(q_push_i && q_full_i))
        else $error("read beat pushed into a full queue");

    no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
        !(q_pop_i && q_empty_i))
        else $error("read beat popped from an empty queue");

endmodule

bind cacheline_adapter adapter_chk chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .bmem_read_i (bmem_read_o),
    .bmem_write_i(bmem_write_o),
    .dfp_resp_i  (dfp_resp_o),
    .q_push_i    (bmem_rvalid_i),
    .q_pop_i     (beat_take),
    .q_full_i    (q_full),
    .q_empty_i   (q_empty)
);

//--- adapter_pkg.sv
package adapter_pkg;

    // Memory beat and line geometry
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BITS      = BEAT_BITS * BEATS_PER_LINE;
    localparam int ADDR_BITS      = 32;

    // Byte step between beats and the line offset that gets cleared
    localparam int BEAT_BYTES  = BEAT_BITS / 8;
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);

    // Beat 0 sits in the lowest 64 bits of a line
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [BEAT_BITS-1:0] beat_t;

    // Byte address as seen by both the cache and memory
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Counts beats within one burst
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

endpackage

//--- burst_ctrl.sv
`timescale 1ns/1ps

module burst_ctrl import adapter_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  addr_t dfp_addr_i,
    input  logic  dfp_read_i,
    input  logic  dfp_write_i,
    input  logic  bmem_ready_i,
    input  logic  q_empty_i,
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    output logic  bmem_write_o,
    output logic  ser_load_o,
    output logic  ser_advance_o,
    output logic  beat_take_o,
    output logic  dfp_resp_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_COLLECT,
        ST_WR_BURST,
        ST_RESP
    } state_t;

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS_PER_LINE - 1);

    state_t    state;
    state_t    state_next;
    beat_idx_t beat_cnt;
    addr_t     base_addr;
    logic      last_beat;

    assign last_beat = (beat_cnt == LAST_BEAT);

    // Strobes decoded from the current state
    assign bmem_read_o   = (state == ST_RD_REQ);
    assign bmem_write_o  = (state == ST_WR_BURST);
    assign dfp_resp_o    = (state == ST_RESP);
    assign beat_take_o   = (state == ST_RD_COLLECT) && !q_empty_i;
    assign ser_advance_o = (state == ST_WR_BURST) && bmem_ready_i;

    // Write line is captured on the edge that starts the burst
    assign ser_load_o = (state == ST_IDLE) && !dfp_read_i && dfp_write_i;

    // Beat address steps by eight bytes from the aligned base
    assign bmem_addr_o = base_addr + (addr_t'(beat_cnt) * addr_t'(BEAT_BYTES));

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Read waits for memory to be ready before issuing
                if (dfp_read_i) begin
                    if (bmem_ready_i) begin
                        state_next = ST_RD_REQ;
                    end
                end else if (dfp_write_i) begin
                    state_next = ST_WR_BURST;
                end
            end
            ST_RD_REQ: begin
                state_next = ST_RD_COLLECT;
            end
            ST_RD_COLLECT: begin
                if (beat_take_o && last_beat) begin
                    state_next = ST_RESP;
                end
            end
            ST_WR_BURST: begin
                if (bmem_ready_i && last_beat) begin
                    state_next = ST_RESP;
                end
            end
            ST_RESP: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Beat counter, cleared while idle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            beat_cnt <= '0;
        end else if (state == ST_IDLE) begin
            beat_cnt <= '0;
        end else if (beat_take_o || ser_advance_o) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Cache holds the address stable, so track it until the request starts
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            base_addr <= {dfp_addr_i[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
        end
    end

endmodule

//--- cacheline_adapter.sv
`timescale 1ns/1ps

module cacheline_adapter import adapter_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset_i,

    // Cache side
    input  addr_t dfp_addr_i,
    input  logic  dfp_read_i,
    input  logic  dfp_write_i,
    input  line_t dfp_wdata_i,
    output line_t dfp_rdata_o,
    output logic  dfp_resp_o,

    // Burst memory side
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    output logic  bmem_write_o,
    output beat_t bmem_wdata_o,
    input  logic  bmem_ready_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i
);

    beat_t q_data;
    logic  q_full;
    logic  q_empty;
    logic  beat_take;
    logic  ser_load;
    logic  ser_advance;

    burst_ctrl ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .dfp_addr_i   (dfp_addr_i),
        .dfp_read_i   (dfp_read_i),
        .dfp_write_i  (dfp_write_i),
        .bmem_ready_i (bmem_ready_i),
        .q_empty_i    (q_empty),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .ser_load_o   (ser_load),
        .ser_advance_o(ser_advance),
        .beat_take_o  (beat_take),
        .dfp_resp_o   (dfp_resp_o)
    );

    // Returning read beats land here straight from memory
    line_queue #(
        .WIDTH(BEAT_BITS),
        .DEPTH(QUEUE_DEPTH)
    ) rd_queue (
        .clk    (clk),
        .reset_i(reset_i),
        .data_i (bmem_rdata_i),
        .push_i (bmem_rvalid_i),
        .pop_i  (beat_take),
        .data_o (q_data),
        .full_o (q_full),
        .empty_o(q_empty)
    );

    line_serializer wr_ser (
        .clk      (clk),
        .load_i   (ser_load),
        .advance_i(ser_advance),
        .line_i   (dfp_wdata_i),
        .beat_o   (bmem_wdata_o)
    );

    // Pop and take are the same strobe
    line_deserializer rd_deser (
        .clk    (clk),
        .reset_i(reset_i),
        .take_i (beat_take),
        .beat_i (q_data),
        .line_o (dfp_rdata_o)
    );

endmodule

//--- cacheline_adapter_tb.sv
`timescale 1ns/1ps

module cacheline_adapter_tb import adapter_pkg::*; ();

    localparam int NUM_REQ        = 200;
    localparam int NUM_LINES      = 16;
    localparam int CYCLES_PER_REQ = 40;
    localparam int TIMEOUT_CYCLES = NUM_REQ * CYCLES_PER_REQ;

    logic  clk;
    logic  reset_i;
    addr_t dfp_addr_i;
    logic  dfp_read_i;
    logic  dfp_write_i;
    line_t dfp_wdata_i;
    line_t dfp_rdata_o;
    logic  dfp_resp_o;
    addr_t bmem_addr_o;
    logic  bmem_read_o;
    logic  bmem_write_o;
    beat_t bmem_wdata_o;
    logic  bmem_ready_i;
    beat_t bmem_rdata_i;
    logic  bmem_rvalid_i;

    // Memory contents and the lines the cache expects to read back
    beat_t mem_model [addr_t];
    line_t exp_line [NUM_LINES];

    // State of the request in flight
    addr_t cur_base;
    line_t cur_wdata;
    bit    busy_read;
    bit    busy_write;
    bit    resp_seen;
    int    read_pulses;
    int    wr_beats;
    int    resp_total;
    bit    prev_ready;

    // Memory read burst in progress
    bit    rd_active;
    addr_t rd_addr;
    int    rd_sent;
    int    rd_wait;

    int    err_count;
    int    cycle_count;

    cacheline_adapter #(
        .QUEUE_DEPTH(4)
    ) UUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .dfp_addr_i   (dfp_addr_i),
        .dfp_read_i   (dfp_read_i),
        .dfp_write_i  (dfp_write_i),
        .dfp_wdata_i  (dfp_wdata_i),
        .dfp_rdata_o  (dfp_rdata_o),
        .dfp_resp_o   (dfp_resp_o),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with requests still outstanding", cycle_count);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic beat_t fill_word(input addr_t a);
        return {a ^ 32'hc3a5_5a3c, a * 32'h9e37_79b9};
    endfunction

    // Lines are spread out so neighbours do not share upper address bits
    function automatic addr_t line_base(input int idx);
        return 32'h4000_0000 + addr_t'(idx) * 32'h0000_0140;
    endfunction

    task automatic fail_now(input string msg);
        err_count++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // One clock of memory model and bus observation, at the falling edge
    task automatic cycle_step();
        logic new_ready;
        @(negedge clk);
        new_ready = ($urandom_range(3, 0) != 0);
        if (bmem_read_o) begin
            if (!busy_read) begin
                fail_now("burst read request seen without a cache read");
            end
            if (!prev_ready) begin
                fail_now("burst read request issued while memory was not ready");
            end
            check_value("bmem_addr_o", line_t'(bmem_addr_o), line_t'(cur_base));
            read_pulses++;
            rd_active = 1'b1;
            rd_addr   = bmem_addr_o;
            rd_sent   = 0;
            rd_wait   = $urandom_range(5, 0);
        end
        // A beat shown now is taken on the coming rising edge if ready is high
        if (bmem_write_o) begin
            if (!busy_write) begin
                fail_now("write beat seen without a cache write");
            end
            if (new_ready) begin
                if (wr_beats >= BEATS_PER_LINE) begin
                    fail_now("more than four write beats in one burst");
                end
                check_value("bmem_addr_o", line_t'(bmem_addr_o),
                            line_t'(cur_base + addr_t'(BEAT_BYTES * wr_beats)));
                check_value("bmem_wdata_o", line_t'(bmem_wdata_o),
                            line_t'(cur_wdata[BEAT_BITS*wr_beats +: BEAT_BITS]));
                mem_model[bmem_addr_o] = bmem_wdata_o;
                wr_beats++;
            end
        end
        // Junk data between beats
        bmem_rvalid_i = 1'b0;
        bmem_rdata_i  = {$urandom(), $urandom()};
        if (rd_active) begin
            if (rd_wait == 0) begin
                bmem_rdata_i  = mem_model[rd_addr + addr_t'(BEAT_BYTES * rd_sent)];
                bmem_rvalid_i = 1'b1;
                rd_sent++;
                if (rd_sent == BEATS_PER_LINE) begin
                    rd_active = 1'b0;
                end else begin
                    rd_wait = $urandom_range(3, 0);
                end
            end else begin
                rd_wait--;
            end
        end
        // Every response pulse from the DUT is counted
        if (dfp_resp_o) begin
            if (!busy_read && !busy_write) begin
                fail_now("cache response with no request pending");
            end
            resp_seen = 1'b1;
            resp_total++;
        end
        bmem_ready_i = new_ready;
        prev_ready   = new_ready;
    endtask

    task automatic do_request(input bit is_write, input int idx, input addr_t addr,
                              input line_t wdata);
        cur_base    = addr & ~addr_t'(31);
        cur_wdata   = wdata;
        read_pulses = 0;
        wr_beats    = 0;
        resp_seen   = 1'b0;
        busy_read   = !is_write;
        busy_write  = is_write;
        dfp_addr_i  = addr;
        dfp_wdata_i = wdata;
        dfp_read_i  = !is_write;
        dfp_write_i = is_write;
        while (!resp_seen) begin
            cycle_step();
        end
        // Cache drops the request in the response cycle
        dfp_read_i  = 1'b0;
        dfp_write_i = 1'b0;
        busy_read   = 1'b0;
        busy_write  = 1'b0;
        if (is_write) begin
            check_value("write beats", line_t'(wr_beats), line_t'(BEATS_PER_LINE));
            exp_line[idx] = wdata;
        end else begin
            check_value("bmem_read_o pulses", line_t'(read_pulses), line_t'(1));
            check_value("dfp_rdata_o", dfp_rdata_o, exp_line[idx]);
        end
        cycle_step();
        if (!is_write) begin
            check_value("dfp_rdata_o", dfp_rdata_o, exp_line[idx]);
        end
    endtask

    initial begin
        bit    is_write;
        int    idx;
        addr_t addr;
        line_t wline;
        void'($urandom(14));
        clk           = 1'b0;
        reset_i       = 1'b1;
        dfp_addr_i    = '0;
        dfp_read_i    = 1'b0;
        dfp_write_i   = 1'b0;
        dfp_wdata_i   = '0;
        bmem_ready_i  = 1'b0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        prev_ready    = 1'b0;
        busy_read     = 1'b0;
        busy_write    = 1'b0;
        rd_active     = 1'b0;
        resp_total    = 0;
        err_count     = 0;
        cycle_count   = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                addr = line_base(i) + addr_t'(BEAT_BYTES * b);
                mem_model[addr] = fill_word(addr);
                exp_line[i][BEAT_BITS*b +: BEAT_BITS] = fill_word(addr);
            end
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        // Quiet bus until the first request
        repeat (5) begin
            cycle_step();
            check_value("bmem_read_o", line_t'(bmem_read_o), line_t'(0));
            check_value("bmem_write_o", line_t'(bmem_write_o), line_t'(0));
            check_value("dfp_resp_o", line_t'(dfp_resp_o), line_t'(0));
        end

        for (int n = 0; n < NUM_REQ; n++) begin
            is_write = ($urandom_range(1, 0) == 1);
            idx      = $urandom_range(NUM_LINES - 1, 0);
            addr     = line_base(idx) | addr_t'($urandom_range(31, 0));
            for (int w = 0; w < 8; w++) begin
                wline[32*w +: 32] = $urandom();
            end
            do_request(is_write, idx, addr, wline);
            repeat ($urandom_range(2, 0)) cycle_step();
        end

        if (err_count == 0 && resp_total == NUM_REQ) begin
            $display("=== PASS ===");
        end else begin
            $display("%0d responses for %0d requests", resp_total, NUM_REQ);
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- line_deserializer.sv
`timescale 1ns/1ps

module line_deserializer import adapter_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  take_i,
    input  beat_t beat_i,
    output line_t line_o
);

    line_t line_q;

    // New beat enters at the top, so the first beat ends up lowest
    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_q <= '0;
        end else if (take_i) begin
            line_q <= {beat_i, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    // Held until the next read starts shifting in
    assign line_o = line_q;

endmodule

//--- line_queue.sv
`timescale 1ns/1ps

module line_queue #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             push_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push_ok;
    logic                pop_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_BITS'(DEPTH));

    // Push into a full queue is dropped
    assign pop_ok  = pop_i && !empty_o;
    assign push_ok = push_i && !full_o;

    // Oldest entry is always on the output
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                // Wrap explicitly so depths that are not a power of two work
                if (wr_ptr == PTR_BITS'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr == PTR_BITS'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Push and pop together leave the count alone
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- line_serializer.sv
`timescale 1ns/1ps

module line_serializer import adapter_pkg::*; (
    input  logic  clk,
    input  logic  load_i,
    input  logic  advance_i,
    input  line_t line_i,
    output beat_t beat_o
);

    // Local copy of the write line, shifted down as beats go out
    line_t shift_q;

    always_ff @(posedge clk) begin
        if (load_i) begin
            shift_q <= line_i;
        end else if (advance_i) begin
            // Next beat moves into the low slice
            shift_q <= {BEAT_BITS'(0), shift_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    // Low slice is the beat on the bus
    assign beat_o = shift_q[BEAT_BITS-1:0];

endmodule

//--- sim.f
adapter_pkg.sv
line_queue.sv
burst_ctrl.sv
line_serializer.sv
line_deserializer.sv
cacheline_adapter.sv
adapter_chk.sv
cacheline_adapter_tb.sv
